// ==== hw/synth_pkg.sv ====
`default_nettype none

package synth_pkg;

   // one key and one voice per slide switch
   localparam int num_voices = 8;

   typedef logic [num_voices-1:0] voice_mask_t;
   // offset binary, midscale is silence
   typedef logic [15:0] sample_t;
   typedef logic [31:0] phase_t;
   typedef logic [7:0] sine_addr_t;
   // 0 to 8 sounding voices
   typedef logic [3:0] voice_count_t;

   // phase step = f * 2^32 / 100 MHz
   // semitones upward from A4 at 440 Hz
   localparam phase_t note_increment [num_voices] = '{
      32'd18898, 32'd20022, 32'd21212, 32'd22474,
      32'd23810, 32'd25226, 32'd26726, 32'd28315
   };

   // roughly 256 / count, applied as multiply then >> 8
   // index 0 mutes the output
   localparam logic [7:0] mix_reciprocal [0:num_voices] = '{
      8'd0, 8'd255, 8'd128, 8'd85, 8'd64, 8'd51, 8'd42, 8'd36, 8'd32
   };

endpackage

`default_nettype wire

// ==== hw/envelope_pkg.sv ====
`default_nettype none

package envelope_pkg;

   // adsr phases, idle means the voice is silent
   typedef enum logic [2:0] {
      env_idle,
      env_attack,
      env_decay,
      env_sustain,
      env_release
   } env_state_t;

   // 16'hffff is just under unity gain
   typedef logic [15:0] env_level_t;

endpackage

`default_nettype wire

// ==== hw/note_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module note_decoder (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire synth_pkg::voice_mask_t sw,
   output synth_pkg::voice_mask_t gate,
   output synth_pkg::voice_mask_t trigger
);

   import synth_pkg::*;

   // gate delayed by one more cycle
   voice_mask_t gate_prev;

   // switches sampled once, gate is the held key level
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         gate <= '0;
         gate_prev <= '0;
      end else begin
         gate <= sw;
         gate_prev <= gate;
      end
   end

   // key-down edge
   // high only in the first cycle of a new gate
   assign trigger = gate & ~gate_prev;

endmodule

`default_nettype wire

// ==== hw/adsr_envelope.sv ====
`timescale 1ns/100ps
`default_nettype none

module adsr_envelope #(
   parameter int clk_freq = 100_000_000,
   parameter int attack_ms = 50,
   parameter int decay_ms = 100,
   parameter int release_ms = 200,
   parameter envelope_pkg::env_level_t peak_level = 16'hf000,
   parameter envelope_pkg::env_level_t sustain_level = 16'h8000
) (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire logic gate,
   input wire logic trigger,
   output envelope_pkg::env_level_t level,
   output logic busy
);

   import envelope_pkg::*;

   // clock cycles per millisecond tick
   localparam int tick_div = clk_freq / 1000;
   localparam int tick_w = $clog2(tick_div);

   // per-tick steps, never below one lsb
   localparam int attack_raw = peak_level / attack_ms;
   localparam int decay_raw = (peak_level - sustain_level) / decay_ms;
   localparam int release_raw = sustain_level / release_ms;
   localparam logic [16:0] attack_inc = 17'((attack_raw > 0) ? attack_raw : 1);
   localparam logic [16:0] decay_inc = 17'((decay_raw > 0) ? decay_raw : 1);
   localparam logic [16:0] release_inc = 17'((release_raw > 0) ? release_raw : 1);

   env_state_t state;
   logic [tick_w-1:0] tick_cnt;
   logic ms_tick;
   // one spare bit so ramps cannot wrap
   logic [16:0] level_ext;

   assign ms_tick = (tick_cnt == tick_w'(tick_div - 1));
   assign level_ext = {1'b0, level};
   assign busy = (state != env_idle);

   // free-running millisecond prescaler
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst || ms_tick) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         state <= env_idle;
         level <= '0;
      end else if (trigger) begin
         // restart attack from wherever the level is
         state <= env_attack;
      end else begin
         case (state)
            env_attack: begin
               if (!gate) begin
                  state <= env_release;
               end else if (ms_tick) begin
                  // clamp at peak then fall toward sustain
                  if (level_ext + attack_inc >= {1'b0, peak_level}) begin
                     level <= peak_level;
                     state <= env_decay;
                  end else begin
                     level <= level + attack_inc[15:0];
                  end
               end
            end
            env_decay: begin
               if (!gate) begin
                  state <= env_release;
               end else if (ms_tick) begin
                  if (level_ext <= {1'b0, sustain_level} + decay_inc) begin
                     level <= sustain_level;
                     state <= env_sustain;
                  end else begin
                     level <= level - decay_inc[15:0];
                  end
               end
            end
            env_sustain: begin
               // held for as long as the key is down
               level <= sustain_level;
               if (!gate) begin
                  state <= env_release;
               end
            end
            env_release: begin
               if (ms_tick) begin
                  if (level_ext <= release_inc) begin
                     level <= '0;
                     state <= env_idle;
                  end else begin
                     level <= level - release_inc[15:0];
                  end
               end
            end
            default: begin
               level <= '0;
               state <= env_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/sine_voice.sv ====
`timescale 1ns/100ps
`default_nettype none

module sine_voice #(
   parameter int voice_index = 0
) (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire logic gate,
   output synth_pkg::sample_t sample
);

   import synth_pkg::*;

   typedef sample_t sine_table_t [256];

   // quarter wave from 1.5x - 0.5x^3, mirrored into four quadrants
   // offset binary around 32768
   function automatic sine_table_t build_sine();
      sine_table_t table_out;
      longint q;
      longint s;
      for (int i = 0; i < 256; i++) begin
         q = i % 64;
         // second and fourth quadrants run backwards
         if ((i / 64) % 2 == 1) begin
            q = 64 - q;
         end
         s = ((3 * q * 64 * 64 - q * q * q) * 32767) / (2 * 64 * 64 * 64);
         if (i < 128) begin
            table_out[i] = sample_t'(32768 + s);
         end else begin
            table_out[i] = sample_t'(32768 - s);
         end
      end
      return table_out;
   endfunction

   localparam sine_table_t sine_table = build_sine();

   phase_t phase;
   sine_addr_t sine_addr;

   // table index from the top phase bits
   assign sine_addr = phase[31:24];

   // phase restarts at zero on every key-down
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst || !gate) begin
         phase <= '0;
      end else begin
         phase <= phase + note_increment[voice_index];
      end
   end

   // registered rom read, second cycle of latency
   always_ff @(posedge clk_100mhz) begin
      sample <= sine_table[sine_addr];
   end

endmodule

`default_nettype wire

// ==== hw/voice_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module voice_mixer (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire synth_pkg::sample_t samples [synth_pkg::num_voices],
   input wire envelope_pkg::env_level_t levels [synth_pkg::num_voices],
   input wire synth_pkg::voice_mask_t busy,
   output synth_pkg::sample_t line_out
);

   import synth_pkg::*;

   sample_t weighted [num_voices];
   voice_count_t busy_count;

   // stage registers
   sample_t scaled_q [num_voices];
   logic [16:0] pair_q [num_voices/2];
   logic [18:0] total_q;
   voice_count_t count1_q;
   voice_count_t count2_q;
   voice_count_t count3_q;

   // final scaling
   logic [26:0] scaled_total;
   logic [18:0] averaged;

   // envelope gain, upper half of the product
   // silent voices contribute nothing
   always_comb begin
      logic [31:0] product;
      busy_count = '0;
      for (int i = 0; i < num_voices; i++) begin
         product = samples[i] * levels[i];
         weighted[i] = busy[i] ? product[31:16] : '0;
         busy_count = busy_count + voice_count_t'(busy[i]);
      end
   end

   // count follows its samples down the pipe
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         count1_q <= '0;
         count2_q <= '0;
         count3_q <= '0;
      end else begin
         count1_q <= busy_count;
         count2_q <= count1_q;
         count3_q <= count2_q;
      end
   end

   // stages 1 to 3, weight then pairwise adder tree
   always_ff @(posedge clk_100mhz) begin
      scaled_q <= weighted;
      for (int j = 0; j < num_voices / 2; j++) begin
         pair_q[j] <= scaled_q[2*j] + scaled_q[2*j+1];
      end
      total_q <= (pair_q[0] + pair_q[1]) + (pair_q[2] + pair_q[3]);
   end

   // divide by voice count via reciprocal table
   assign scaled_total = total_q * mix_reciprocal[count3_q];
   assign averaged = scaled_total[26:8];

   // stage 4, clip at full scale
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         line_out <= '0;
      end else if (|averaged[18:16]) begin
         line_out <= '1;
      end else begin
         line_out <= averaged[15:0];
      end
   end

endmodule

`default_nettype wire

// ==== hw/pdm_modulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module pdm_modulator (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire synth_pkg::sample_t sample,
   output logic bit_out
);

   // low 16 bits hold the error, bit 16 the carry
   logic [16:0] acc;

   // first-order sigma-delta
   // ones density = sample / 65536
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         acc <= '0;
      end else begin
         acc <= {1'b0, acc[15:0]} + {1'b0, sample};
      end
   end

   // carry out is already registered
   assign bit_out = acc[16];

endmodule

`default_nettype wire

// ==== hw/synth_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_top #(
   parameter int clk_freq = 100_000_000,
   parameter int attack_ms = 50,
   parameter int decay_ms = 100,
   parameter int release_ms = 200,
   parameter envelope_pkg::env_level_t peak_level = 16'hf000,
   parameter envelope_pkg::env_level_t sustain_level = 16'h8000
) (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire synth_pkg::voice_mask_t sw,
   output logic spkl,
   output logic spkr,
   output synth_pkg::voice_mask_t led,
   output synth_pkg::sample_t line_out
);

   import synth_pkg::*;
   import envelope_pkg::*;

   voice_mask_t gate;
   voice_mask_t trigger;
   voice_mask_t busy;
   sample_t voice_sample [num_voices];
   env_level_t voice_level [num_voices];
   logic pdm_bit;

   // switches to gate levels and key-down pulses
   note_decoder note_decoder_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .sw(sw),
      .gate(gate),
      .trigger(trigger)
   );

   // one oscillator and one envelope per key
   for (genvar v = 0; v < num_voices; v++) begin : g_voice
      sine_voice #(
         .voice_index(v)
      ) sine_voice_inst (
         .clk_100mhz(clk_100mhz),
         .sys_rst(sys_rst),
         .gate(gate[v]),
         .sample(voice_sample[v])
      );

      adsr_envelope #(
         .clk_freq(clk_freq),
         .attack_ms(attack_ms),
         .decay_ms(decay_ms),
         .release_ms(release_ms),
         .peak_level(peak_level),
         .sustain_level(sustain_level)
      ) adsr_envelope_inst (
         .clk_100mhz(clk_100mhz),
         .sys_rst(sys_rst),
         .gate(gate[v]),
         .trigger(trigger[v]),
         .level(voice_level[v]),
         .busy(busy[v])
      );
   end

   // weighted average of sounding voices
   voice_mixer voice_mixer_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .samples(voice_sample),
      .levels(voice_level),
      .busy(busy),
      .line_out(line_out)
   );

   pdm_modulator pdm_modulator_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .sample(line_out),
      .bit_out(pdm_bit)
   );

   // same mono bitstream on both speaker pins
   assign spkl = pdm_bit;
   assign spkr = pdm_bit;
   assign led = busy;

endmodule

`default_nettype wire

// ==== verif/synth_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_assertions (
   input wire logic clk_100mhz,
   input wire logic sys_rst,
   input wire logic spkl,
   input wire logic spkr,
   input wire synth_pkg::voice_mask_t led,
   input wire synth_pkg::sample_t line_out
);

   // failures so far, read by the testbench at the end
   int fail_count = 0;

   // one mono bitstream on both pins
   speakers_match: assert property (@(posedge clk_100mhz) spkl == spkr)
      else begin
         $error("spkl and spkr differ");
         fail_count++;
      end

   // envelopes come out of reset idle
   led_clear_after_reset: assert property (@(posedge clk_100mhz) sys_rst |=> led == '0)
      else begin
         $error("led not clear in the cycle after reset");
         fail_count++;
      end

   // mixer is 4 deep, so 5 idle cycles must give silence
   silent_when_idle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      ($past(led, 1) == '0 && $past(led, 2) == '0 && $past(led, 3) == '0 &&
       $past(led, 4) == '0 && $past(led, 5) == '0) |-> line_out == '0)
      else begin
         $error("line_out nonzero after 5 idle cycles");
         fail_count++;
      end

endmodule

bind synth_top synth_assertions synth_assertions_inst (
   .clk_100mhz(clk_100mhz),
   .sys_rst(sys_rst),
   .spkl(spkl),
   .spkr(spkr),
   .led(led),
   .line_out(line_out)
);

`default_nettype wire

// ==== verif/synth_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_tb;

   import synth_pkg::*;
   import envelope_pkg::*;

   // 10 cycles per millisecond tick
   localparam int clk_freq = 10000;
   localparam int tick_cycles = clk_freq / 1000;
   localparam int attack_ms = 4;
   localparam int decay_ms = 4;
   localparam int release_ms = 6;
   localparam env_level_t peak_level = 16'hf000;
   localparam env_level_t sustain_level = 16'h8000;

   // timeouts, in cycles
   localparam int key_on_timeout = 20;
   localparam int release_timeout = 200;
   localparam int drain_timeout = 10;
   // attack and decay take about 9 ticks
   localparam int sustain_hold = 150;
   // prescaler phase can shorten release by up to one tick
   localparam int release_margin = tick_cycles;
   localparam int density_window = 2048;
   localparam int density_tolerance = 2;

   logic clk_100mhz = 1'b0;
   logic sys_rst;
   voice_mask_t sw;
   logic spkl;
   logic spkr;
   voice_mask_t led;
   sample_t line_out;
   int seed = 32'h41df_6449;

   synth_top #(
      .clk_freq(clk_freq),
      .attack_ms(attack_ms),
      .decay_ms(decay_ms),
      .release_ms(release_ms),
      .peak_level(peak_level),
      .sustain_level(sustain_level)
   ) synth_top_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .sw(sw),
      .spkl(spkl),
      .spkr(spkr),
      .led(led),
      .line_out(line_out)
   );

   // 100 MHz
   always #5 clk_100mhz = ~clk_100mhz;

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic value_error(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      abort_run();
   endtask

   task automatic timeout_error(input string msg);
      $display("timed out at %0t ns %s", $time, msg);
      abort_run();
   endtask

   // inputs change and outputs are read 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk_100mhz);
      #1;
   endtask

   task automatic compare_mask(input voice_mask_t actual, input voice_mask_t expected,
                               input string what);
      if (actual !== expected) begin
         value_error($sformatf("%s is %b, expected %b", what, actual, expected));
      end
   endtask

   task automatic compare_sample(input sample_t actual, input sample_t expected,
                                 input string what);
      if (actual !== expected) begin
         value_error($sformatf("%s is %h, expected %h", what, actual, expected));
      end
   endtask

   // upper bound check, x fails too
   task automatic limit_sample(input sample_t actual, input sample_t limit, input string what);
      if (!(actual <= limit)) begin
         value_error($sformatf("%s is %h, above limit %h", what, actual, limit));
      end
   endtask

   task automatic compare_bit(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         value_error($sformatf("%s is %b, expected %b", what, actual, expected));
      end
   endtask

   // poll one led bit, cycles returns the time taken
   task automatic wait_led_bit(input int idx, input logic value, input int limit,
                               input string what, output int cycles);
      cycles = 0;
      while (led[idx] !== value) begin
         if (cycles >= limit) begin
            timeout_error(what);
         end
         next_cycle();
         cycles++;
      end
   endtask

   // all voices idle, then mixer pipeline drained
   task automatic wait_quiet();
      int cycles;
      cycles = 0;
      while (led !== '0) begin
         if (cycles >= release_timeout) begin
            timeout_error("waiting for every voice to go idle");
         end
         next_cycle();
         cycles++;
      end
      cycles = 0;
      while (line_out !== '0) begin
         if (cycles >= drain_timeout) begin
            timeout_error("waiting for line_out to return to zero");
         end
         next_cycle();
         cycles++;
      end
   endtask

   task automatic test_reset_silence();
      sw = '0;
      for (int i = 0; i < 200; i++) begin
         next_cycle();
         compare_mask(led, '0, "led with no key");
         compare_sample(line_out, '0, "line_out with no key");
         compare_bit(spkl, 1'b0, "spkl with no key");
         compare_bit(spkr, 1'b0, "spkr with no key");
      end
   endtask

   task automatic test_key_on(input int idx);
      voice_mask_t mask;
      int cycles;
      mask = voice_mask_t'(1) << idx;
      sw = mask;
      cycles = 0;
      while (led[idx] !== 1'b1) begin
         compare_mask(led & ~mask, '0, "led bits of keys not pressed");
         if (cycles >= key_on_timeout) begin
            timeout_error("waiting for the pressed key's led bit to rise");
         end
         next_cycle();
         cycles++;
      end
      // on into sustain, only the one voice sounding
      for (int i = 0; i < sustain_hold; i++) begin
         next_cycle();
         compare_mask(led, mask, "led while one key is held");
      end
   endtask

   task automatic test_release(input int idx);
      int cycles;
      sw = '0;
      wait_led_bit(idx, 1'b0, release_timeout, "waiting for the released voice to go idle",
                   cycles);
      if (cycles < release_ms * tick_cycles - release_margin) begin
         value_error($sformatf("led bit %0d cleared after only %0d release cycles",
                               idx, cycles));
      end
      wait_quiet();
   endtask

   // mixer average never above the envelope peak
   task automatic test_mix_bound(input voice_mask_t mask);
      logic seen_sound;
      seen_sound = 1'b0;
      sw = mask;
      for (int i = 0; i < 2 * sustain_hold; i++) begin
         next_cycle();
         limit_sample(line_out, sample_t'(peak_level), "line_out while a chord is held");
         if (line_out != '0) begin
            seen_sound = 1'b1;
         end
      end
      if (!seen_sound) begin
         value_error($sformatf("line_out stayed zero while keys %b were held", mask));
      end
      sw = '0;
      wait_quiet();
   endtask

   task automatic test_density(input voice_mask_t mask);
      int ones;
      longint level_sum;
      longint expected;
      sw = mask;
      for (int i = 0; i < sustain_hold; i++) begin
         next_cycle();
      end
      ones = 0;
      level_sum = 0;
      for (int i = 0; i < density_window; i++) begin
         next_cycle();
         ones = ones + int'(spkl);
         level_sum = level_sum + longint'(line_out);
      end
      // ones density is sample / 65536
      expected = level_sum / 65536;
      if (ones > expected + density_tolerance || ones + density_tolerance < expected) begin
         value_error($sformatf("spkl had %0d ones in %0d cycles, expected about %0d",
                               ones, density_window, expected));
      end
      sw = '0;
      wait_quiet();
   endtask

   task automatic test_retrigger(input int idx);
      voice_mask_t mask;
      int cycles;
      mask = voice_mask_t'(1) << idx;
      sw = mask;
      wait_led_bit(idx, 1'b1, key_on_timeout, "waiting for the retrigger key's led bit",
                   cycles);
      for (int i = 0; i < sustain_hold; i++) begin
         next_cycle();
      end
      // short release, well inside the release ramp
      sw = '0;
      for (int i = 0; i < 2 * tick_cycles; i++) begin
         next_cycle();
         compare_mask(led & mask, mask, "led bit during early release");
      end
      sw = mask;
      for (int i = 0; i < sustain_hold; i++) begin
         next_cycle();
         compare_mask(led & mask, mask, "led bit after retrigger");
      end
      sw = '0;
      wait_led_bit(idx, 1'b0, release_timeout, "waiting for the final release to finish",
                   cycles);
      wait_quiet();
   endtask

   initial begin
      int idx;
      voice_mask_t mask;
      sys_rst = 1'b1;
      sw = '0;
      repeat (4) @(posedge clk_100mhz);
      #1;
      sys_rst = 1'b0;

      test_reset_silence();
      idx = $unsigned($random(seed)) % num_voices;
      test_key_on(idx);
      test_release(idx);
      for (int n = 0; n < 3; n++) begin
         mask = voice_mask_t'($random(seed));
         if (mask == '0) begin
            mask = 8'h01;
         end
         test_mix_bound(mask);
      end
      // chord of at least two keys
      mask = voice_mask_t'($random(seed)) | 8'h81;
      test_density(mask);
      idx = $unsigned($random(seed)) % num_voices;
      test_retrigger(idx);

      if (synth_top_inst.synth_assertions_inst.fail_count != 0) begin
         $display("bound assertions failed %0d times",
                  synth_top_inst.synth_assertions_inst.fail_count);
         abort_run();
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/synth_pkg.sv
hw/envelope_pkg.sv
hw/note_decoder.sv
hw/adsr_envelope.sv
hw/sine_voice.sv
hw/voice_mixer.sv
hw/pdm_modulator.sv
hw/synth_top.sv
verif/synth_assertions.sv
verif/synth_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv verif/*.sv)

obj_dir/Vsynth_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module synth_tb -f sim.f

run: obj_dir/Vsynth_tb
	./obj_dir/Vsynth_tb | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean
